// ==== Bender.yml ====
package:
  name: fdiv_engine

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fdiv_pkg.sv
      - fp16_div/fp16_div.sv
      - rtl/fdiv_shared_mem.sv
      - rtl/fdiv_sequencer.sv
      - rtl/fdiv_apb_regs.sv
      - rtl/fdiv_engine_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_fdiv_engine.sv

// ==== common/fdiv_defs.svh ====
// Sizes, address map and latency of the fp16 divide engine, included by RTL and testbench
`ifndef FDIV_DEFS_SVH
`define FDIV_DEFS_SVH

// ----------------------------------------------------------
// Scratch memory
// ----------------------------------------------------------
// Words 0 to 31 hold operand pairs and words 32 to 63 hold quotients
`define FDIV_MEM_DEPTH   64
`define FDIV_RES_BASE    32
// Largest legal batch
`define FDIV_MAX_OPS     32

// Divider in_valid to out_valid in cycles
`define FDIV_LATENCY     14

// ----------------------------------------------------------
// APB byte address map
// ----------------------------------------------------------
`define FDIV_ADDR_CTRL   12'h000
`define FDIV_ADDR_COUNT  12'h004
`define FDIV_ADDR_STATUS 12'h008
// Memory word n sits at WIN + 4*n
`define FDIV_ADDR_WIN    12'h100

`endif

// ==== common/fdiv_pkg.sv ====
// Shared types of the fp16 divide engine, imported by every RTL block and the testbench
`include "fdiv_defs.svh"

package fdiv_pkg;

    // Half-precision value, sign in bit 15
    typedef logic [15:0] fp16_t;
    typedef logic [$clog2(`FDIV_MEM_DEPTH)-1:0] mem_addr_t;
    typedef logic [31:0] mem_word_t;
    // Holds 0 up to the batch limit inclusive
    typedef logic [$clog2(`FDIV_MAX_OPS+1)-1:0] op_count_t;
    typedef logic [11:0] apb_addr_t;

    // Operand word layout, divisor in the upper half
    typedef struct packed {
        fp16_t b;
        fp16_t a;
    } fp16_pair_t;

    // One requester port of the scratch memory
    typedef struct packed {
        logic      req;
        logic      we;
        mem_addr_t addr;
        mem_word_t wdata;
    } mem_req_t;

    // APB3 master to slave
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        mem_word_t pwdata;
    } apb_req_t;

    // APB3 slave to master
    typedef struct packed {
        mem_word_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Batch sequencer
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } seq_state_e;

endpackage

// ==== fdiv_engine.f ====
+incdir+common
common/fdiv_pkg.sv
fp16_div/fp16_div.sv
rtl/fdiv_shared_mem.sv
rtl/fdiv_sequencer.sv
rtl/fdiv_apb_regs.sv
rtl/fdiv_engine_top.sv
tb/tb_fdiv_engine.sv

// ==== fp16_div/fp16_div.sv ====
// Pipelined fp16 divider with truncation, accepts one pair per cycle at fixed latency
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module fp16_div (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  fdiv_pkg::fp16_pair_t in_ops,
    output logic                 out_valid,
    output fdiv_pkg::fp16_t      result
);
    import fdiv_pkg::*;

    // Unpack and output registers take two of the cycles
    localparam int NUM_STAGES = `FDIV_LATENCY - 2;

    // One operand after unpack
    typedef struct packed {
        logic              nan;
        logic              inf;
        logic              zero;
        logic [10:0]       sig;
        logic signed [6:0] exp;
    } unpacked_t;

    // Everything that moves down the pipe together
    typedef struct packed {
        logic              valid;
        logic              special;
        fp16_t             special_res;
        logic              sign;
        logic signed [6:0] exp;
        logic [10:0]       divisor;
        logic [11:0]       rem;
        logic [11:0]       quo;
    } div_stage_t;

    // Leading zeros of an 11-bit significand
    function automatic logic [3:0] lzc11(input logic [10:0] m);
        logic [3:0] n;
        n = 4'd11;
        for (int k = 0; k < 11; k++) begin
            if (m[k]) begin
                n = 4'(10 - k);
            end
        end
        return n;
    endfunction

    function automatic unpacked_t unpack(input fp16_t v);
        unpacked_t  u;
        logic [3:0] lz;
        lz = lzc11({1'b0, v[9:0]});
        u.nan  = (v[14:10] == 5'h1f) && (v[9:0] != '0);
        u.inf  = (v[14:10] == 5'h1f) && (v[9:0] == '0);
        u.zero = (v[14:0] == '0);
        if (v[14:10] == '0) begin
            // Denormal
            // Move the leading one up to the hidden bit and lower the exponent to match
            u.sig = {1'b0, v[9:0]} << lz;
            u.exp = 7'sd1 - signed'({3'b0, lz});
        end else begin
            u.sig = {1'b1, v[9:0]};
            u.exp = signed'({2'b0, v[14:10]});
        end
        return u;
    endfunction

    unpacked_t         ua;
    unpacked_t         ub;
    div_stage_t        s0_next;
    div_stage_t        pipe [0:NUM_STAGES];
    div_stage_t        last;
    logic signed [6:0] fexp;
    logic [9:0]        frac;
    logic [10:0]       sub_sig;
    fp16_t             packed_res;

    // ----------------------------------------------------------
    // Stage 1 unpack and special cases
    // ----------------------------------------------------------
    assign ua = unpack(in_ops.a);
    assign ub = unpack(in_ops.b);

    always_comb begin
        s0_next.valid   = in_valid;
        s0_next.sign    = in_ops.a[15] ^ in_ops.b[15];
        s0_next.exp     = ua.exp - ub.exp + 7'sd15;
        s0_next.divisor = ub.sig;
        // Both significands in [1,2) so the first step yields the integer bit
        s0_next.rem     = {1'b0, ua.sig};
        s0_next.quo     = '0;
        s0_next.special = 1'b1;
        if (ua.nan || ub.nan || (ua.inf && ub.inf) || (ua.zero && ub.zero)) begin
            s0_next.special_res = 16'h7e01;
        end else if (ua.inf || ub.zero) begin
            // Signed infinity
            s0_next.special_res = {s0_next.sign, 5'h1f, 10'h0};
        end else if (ua.zero || ub.inf) begin
            // Signed zero
            s0_next.special_res = {s0_next.sign, 15'h0};
        end else begin
            s0_next.special     = 1'b0;
            s0_next.special_res = '0;
        end
    end

    always_ff @(posedge clk) begin
        pipe[0] <= s0_next;
        if (!rst_n) begin
            pipe[0].valid <= 1'b0;
        end
    end

    // ----------------------------------------------------------
    // Restoring divide, one quotient bit per stage
    // ----------------------------------------------------------
    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_div
        logic        ge;
        logic [11:0] diff;
        logic [10:0] kept;

        assign ge   = (pipe[i].rem >= {1'b0, pipe[i].divisor});
        assign diff = pipe[i].rem - {1'b0, pipe[i].divisor};
        // Partial remainder stays below the divisor after this step
        assign kept = ge ? diff[10:0] : pipe[i].rem[10:0];

        always_ff @(posedge clk) begin
            // Sign, exponent and special result ride along unchanged
            pipe[i+1]     <= pipe[i];
            pipe[i+1].rem <= {kept, 1'b0};
            pipe[i+1].quo <= {pipe[i].quo[10:0], ge};
            if (!rst_n) begin
                pipe[i+1].valid <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // Normalize and pack
    // ----------------------------------------------------------
    assign last = pipe[NUM_STAGES];

    always_comb begin
        // Quotient lies in (0.5,2), so at most one place of left shift
        if (last.quo[11]) begin
            fexp = last.exp;
            frac = last.quo[10:1];
        end else begin
            fexp = last.exp - 7'sd1;
            frac = last.quo[9:0];
        end
        // Only meaningful when fexp is zero or negative
        sub_sig = {1'b1, frac} >> (7'sd1 - fexp);
        if (last.special) begin
            packed_res = last.special_res;
        end else if (fexp >= 7'sd31) begin
            // Overflow to infinity
            packed_res = {last.sign, 5'h1f, 10'h0};
        end else if (fexp <= 7'sd0) begin
            // Underflow to denormal or zero by truncating shift
            packed_res = {last.sign, 5'h0, sub_sig[9:0]};
        end else begin
            packed_res = {last.sign, fexp[4:0], frac};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= last.valid;
        end
        result <= packed_res;
    end

endmodule

// ==== rtl/fdiv_apb_regs.sv ====
// APB3 slave with control, count and status registers and a window onto the scratch memory
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module fdiv_apb_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  fdiv_pkg::apb_req_t  apb_in,
    output fdiv_pkg::apb_rsp_t  apb_out,
    output logic                start,
    output fdiv_pkg::op_count_t count,
    input  logic                busy,
    input  logic                done,
    output fdiv_pkg::mem_req_t  mem_req,
    input  logic                mem_gnt,
    input  fdiv_pkg::mem_word_t mem_rdata
);
    import fdiv_pkg::*;

    logic      access;
    logic      win_hit;
    logic      hit_ctrl;
    logic      hit_count;
    logic      hit_status;
    logic      reg_acc;
    logic      reg_err;
    logic      win_ack;
    mem_word_t reg_rdata;

    // ----------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------
    assign access     = apb_in.psel && apb_in.penable;
    assign win_hit    = (apb_in.paddr >= `FDIV_ADDR_WIN) &&
                        (apb_in.paddr < `FDIV_ADDR_WIN + 4 * `FDIV_MEM_DEPTH);
    assign hit_ctrl   = (apb_in.paddr == `FDIV_ADDR_CTRL);
    assign hit_count  = (apb_in.paddr == `FDIV_ADDR_COUNT);
    assign hit_status = (apb_in.paddr == `FDIV_ADDR_STATUS);
    // Everything outside the window finishes in the first access cycle
    assign reg_acc    = access && !win_hit;

    always_comb begin
        reg_err   = 1'b0;
        reg_rdata = '0;
        if (hit_ctrl) begin
            // Only one batch in flight
            reg_err = apb_in.pwrite && apb_in.pwdata[0] && busy;
        end else if (hit_count) begin
            reg_err   = apb_in.pwrite && (apb_in.pwdata > `FDIV_MAX_OPS);
            reg_rdata = mem_word_t'(count);
        end else if (hit_status) begin
            reg_err   = apb_in.pwrite;
            reg_rdata = {30'h0, done, busy};
        end else begin
            // Unmapped
            reg_err = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    assign start = reg_acc && hit_ctrl && apb_in.pwrite && apb_in.pwdata[0] && !reg_err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (reg_acc && hit_count && apb_in.pwrite && !reg_err) begin
            count <= op_count_t'(apb_in.pwdata);
        end
    end

    // ----------------------------------------------------------
    // Memory window
    // ----------------------------------------------------------
    // Hold off while a batch runs, then ask once and wait for the word
    always_comb begin
        mem_req       = '0;
        mem_req.req   = access && win_hit && !busy && !win_ack;
        mem_req.we    = apb_in.pwrite;
        mem_req.addr  = mem_addr_t'((apb_in.paddr - `FDIV_ADDR_WIN) >> 2);
        mem_req.wdata = apb_in.pwdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_ack <= 1'b0;
        end else begin
            win_ack <= mem_req.req && mem_gnt;
        end
    end

    // Response
    always_comb begin
        apb_out.pready  = reg_acc || win_ack;
        apb_out.pslverr = reg_acc && reg_err;
        apb_out.prdata  = win_ack ? mem_rdata : reg_rdata;
    end

endmodule

// ==== rtl/fdiv_engine_top.sv ====
// Top of the fp16 divide engine, APB slave, sequencer, divider and shared memory wired together
`timescale 1ns/1ps

module fdiv_engine_top (
    input  logic               clk,
    input  logic               rst_n,
    input  fdiv_pkg::apb_req_t apb_in,
    output fdiv_pkg::apb_rsp_t apb_out
);
    import fdiv_pkg::*;

    logic       start;
    logic       busy;
    logic       done;
    op_count_t  count;
    mem_req_t   seq_req;
    mem_req_t   host_req;
    logic       host_gnt;
    mem_word_t  seq_rdata;
    mem_word_t  host_rdata;
    logic       div_valid;
    fp16_pair_t div_ops;
    logic       div_out_valid;
    fp16_t      div_result;

    // Host side
    fdiv_apb_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_in    (apb_in),
        .apb_out   (apb_out),
        .start     (start),
        .count     (count),
        .busy      (busy),
        .done      (done),
        .mem_req   (host_req),
        .mem_gnt   (host_gnt),
        .mem_rdata (host_rdata)
    );

    fdiv_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .count         (count),
        .busy          (busy),
        .done          (done),
        .mem_req       (seq_req),
        .mem_rdata     (seq_rdata),
        .div_valid     (div_valid),
        .div_ops       (div_ops),
        .div_out_valid (div_out_valid),
        .div_result    (div_result)
    );

    fp16_div u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (div_valid),
        .in_ops    (div_ops),
        .out_valid (div_out_valid),
        .result    (div_result)
    );

    // Sequencer holds top priority, so its grant is always its request
    fdiv_shared_mem u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .seq_req    (seq_req),
        .seq_gnt    (),
        .seq_rdata  (seq_rdata),
        .host_req   (host_req),
        .host_gnt   (host_gnt),
        .host_rdata (host_rdata)
    );

endmodule

// ==== rtl/fdiv_sequencer.sv ====
// Batch controller streaming operand words through the divider and writing quotients back
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module fdiv_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  fdiv_pkg::op_count_t  count,
    output logic                 busy,
    output logic                 done,
    output fdiv_pkg::mem_req_t   mem_req,
    input  fdiv_pkg::mem_word_t  mem_rdata,
    output logic                 div_valid,
    output fdiv_pkg::fp16_pair_t div_ops,
    input  logic                 div_out_valid,
    input  fdiv_pkg::fp16_t      div_result
);
    import fdiv_pkg::*;

    seq_state_e state;
    op_count_t  total;
    op_count_t  fetch_ptr;
    op_count_t  wb_ptr;
    logic       fetch;
    logic       rd_pend;
    logic       last_wb;

    assign busy = (state != IDLE);

    // Write-back owns the port whenever a quotient comes out
    assign fetch   = (state == RUN) && !div_out_valid;
    assign last_wb = div_out_valid && (wb_ptr == op_count_t'(total - 1'b1));

    // ----------------------------------------------------------
    // Memory port
    // ----------------------------------------------------------
    always_comb begin
        mem_req = '0;
        if (busy && div_out_valid) begin
            mem_req.req   = 1'b1;
            mem_req.we    = 1'b1;
            mem_req.addr  = mem_addr_t'(`FDIV_RES_BASE) + mem_addr_t'(wb_ptr);
            mem_req.wdata = {16'h0, div_result};
        end else if (fetch) begin
            mem_req.req  = 1'b1;
            mem_req.addr = mem_addr_t'(fetch_ptr);
        end
    end

    // Fetched word goes straight into the divider
    assign div_valid = rd_pend;
    assign div_ops   = fp16_pair_t'(mem_rdata);

    // ----------------------------------------------------------
    // Batch FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            total     <= '0;
            fetch_ptr <= '0;
            wb_ptr    <= '0;
            done      <= 1'b0;
            rd_pend   <= 1'b0;
        end else begin
            rd_pend <= fetch;
            case (state)
                IDLE: begin
                    if (start) begin
                        // Empty batch finishes on the spot
                        done      <= (count == '0);
                        total     <= count;
                        fetch_ptr <= '0;
                        wb_ptr    <= '0;
                        if (count != '0) begin
                            state <= RUN;
                        end
                    end
                end
                RUN, DRAIN: begin
                    if (fetch) begin
                        fetch_ptr <= fetch_ptr + 1'b1;
                        if (fetch_ptr + 1'b1 == total) begin
                            state <= DRAIN;
                        end
                    end
                    if (div_out_valid) begin
                        wb_ptr <= wb_ptr + 1'b1;
                    end
                    // Done rises with the edge that writes the last quotient
                    if (last_wb) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/fdiv_shared_mem.sv ====
// Single-port scratch memory shared by sequencer and host behind a fixed-priority arbiter
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module fdiv_shared_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  fdiv_pkg::mem_req_t  seq_req,
    output logic                seq_gnt,
    output fdiv_pkg::mem_word_t seq_rdata,
    input  fdiv_pkg::mem_req_t  host_req,
    output logic                host_gnt,
    output fdiv_pkg::mem_word_t host_rdata
);
    import fdiv_pkg::*;

    mem_word_t mem [`FDIV_MEM_DEPTH];
    mem_req_t  sel;
    mem_word_t rdata_q;

    // ----------------------------------------------------------
    // Arbiter
    // ----------------------------------------------------------
    // Sequencer always wins
    // Host is granted only in a cycle the sequencer leaves free
    assign seq_gnt  = seq_req.req;
    assign host_gnt = host_req.req && !seq_req.req;
    assign sel      = seq_req.req ? seq_req : host_req;

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (sel.req && sel.we) begin
            mem[sel.addr] <= sel.wdata;
        end
    end

    // Read word lands one cycle after the grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (sel.req && !sel.we) begin
            rdata_q <= mem[sel.addr];
        end
    end

    // Each requester knows whether the word is its own
    assign seq_rdata  = rdata_q;
    assign host_rdata = rdata_q;

endmodule

// ==== tb/fdiv_golden.mem ====
// Operand a, operand b and expected quotient, 16 bits each in hex
// Quotients truncated toward zero
3c003c003c00
3c0040003800
3c0042003555
4900420042aa
c0004200b955
// Denormal operands and results
00013c000001
020004003800
3c0002007800
040042000155
// Overflow and underflow
7bff38007c00
000140000000
// Special cases
7e003c007e01
000000007e01
7c007c007e01
c0000000fc00
fc004000fc00
800040008000
4000fc008000

// ==== tb/tb_fdiv_engine.sv ====
// Self-checking testbench for the fp16 divide engine, runs golden vectors over APB
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module tb_fdiv_engine;
    import fdiv_pkg::*;

    localparam int GOLDEN_N = 18;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_in;
    apb_rsp_t    apb_out;

    // Operand a in [47:32], operand b in [31:16], quotient in [15:0]
    logic [47:0] golden [0:GOLDEN_N-1];
    // Expected contents of the scratch memory
    mem_word_t   model [0:`FDIV_MEM_DEPTH-1];

    int unsigned cycles = 0;
    // Starts with room for the reset cycles
    int unsigned budget = 8;

    fdiv_engine_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_in  (apb_in),
        .apb_out (apb_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH %s: expected %h, actual %h",
                                name, expected, actual));
        end
    endtask

    // Limit grows with the work still to come
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 2 * budget) begin
            abort_run("Timeout, the run took longer than its cycle limit");
        end
    end

    function automatic apb_addr_t word_addr(input int w);
        return apb_addr_t'(`FDIV_ADDR_WIN + 4 * w);
    endfunction

    // One APB3 transfer, response sampled mid cycle
    task automatic bus_transfer(input logic wr, input apb_addr_t addr, input mem_word_t wdata,
                                output mem_word_t rdata, output logic err);
        apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = wr;
        req.paddr  = addr;
        req.pwdata = wdata;
        @(posedge clk);
        apb_in <= req;
        @(posedge clk);
        apb_in.penable <= 1'b1;
        @(negedge clk);
        while (!apb_out.pready) begin
            @(negedge clk);
        end
        rdata = apb_out.prdata;
        err   = apb_out.pslverr;
        // Transfer ends on this edge
        @(posedge clk);
        apb_in <= '0;
    endtask

    task automatic write_word(input string name, input apb_addr_t addr, input mem_word_t data,
                              input logic exp_err);
        mem_word_t rd;
        logic      err;
        budget += 6;
        bus_transfer(1'b1, addr, data, rd, err);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    task automatic read_word(input string name, input apb_addr_t addr, input logic exp_err,
                             output mem_word_t data);
        logic err;
        budget += 6;
        bus_transfer(1'b0, addr, '0, data, err);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    // Polls stay inside the batch budget
    task automatic poll_until_done(input string name);
        mem_word_t rd;
        logic      err;
        rd = '0;
        while (!rd[1]) begin
            bus_transfer(1'b0, `FDIV_ADDR_STATUS, '0, rd, err);
            check_value({name, " poll pslverr"}, 32'h0, 32'(err));
        end
    endtask

    // Load n golden pairs, run them and check every quotient
    task automatic run_batch(input string name, input int first, input int n, input bit probe);
        fp16_pair_t pair;
        mem_word_t  rd;
        for (int k = 0; k < n; k++) begin
            pair.a = golden[first + k][47:32];
            pair.b = golden[first + k][31:16];
            write_word({name, " operand"}, word_addr(k), mem_word_t'(pair), 1'b0);
            model[k] = mem_word_t'(pair);
        end
        write_word({name, " count"}, `FDIV_ADDR_COUNT, mem_word_t'(n), 1'b0);
        write_word({name, " start"}, `FDIV_ADDR_CTRL, 32'h1, 1'b0);
        budget += 2 * n + `FDIV_LATENCY + 10;
        if (n > 0) begin
            // Start clears done, batch still running
            read_word({name, " status after start"}, `FDIV_ADDR_STATUS, 1'b0, rd);
            check_value({name, " status after start"}, 32'h1, rd);
        end
        if (probe) begin
            write_word({name, " start while busy"}, `FDIV_ADDR_CTRL, 32'h1, 1'b1);
            read_word({name, " status after refused start"}, `FDIV_ADDR_STATUS, 1'b0, rd);
            check_value({name, " status after refused start"}, 32'h1, rd);
            // Last quotient is written on the edge that sets done
            // A read let through any earlier would see the old word
            read_word({name, " window read while busy"},
                      word_addr(`FDIV_RES_BASE + n - 1), 1'b0, rd);
            check_value({name, " window read while busy"},
                        32'(golden[first + n - 1][15:0]), 32'(rd[15:0]));
            read_word({name, " status after held read"}, `FDIV_ADDR_STATUS, 1'b0, rd);
            check_value({name, " status after held read"}, 32'h2, rd);
        end
        poll_until_done(name);
        read_word({name, " final status"}, `FDIV_ADDR_STATUS, 1'b0, rd);
        check_value({name, " final status"}, 32'h2, rd);
        for (int k = 0; k < n; k++) begin
            read_word({name, " result"}, word_addr(`FDIV_RES_BASE + k), 1'b0, rd);
            check_value({name, " result"}, 32'(golden[first + k][15:0]), 32'(rd[15:0]));
            model[`FDIV_RES_BASE + k] = rd;
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        int        split;
        mem_word_t rd;
        void'($urandom(32'h79b9));
        apb_in = '0;
        rst_n  = 1'b0;
        $readmemh("tb/fdiv_golden.mem", golden);
        if (^golden[GOLDEN_N-1] === 1'bx) begin
            abort_run("Golden vector file tb/fdiv_golden.mem could not be read");
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Registers after reset
        read_word("reset status", `FDIV_ADDR_STATUS, 1'b0, rd);
        check_value("reset status", 32'h0, rd);
        read_word("reset count", `FDIV_ADDR_COUNT, 1'b0, rd);
        check_value("reset count", 32'h0, rd);

        // Random fill of the whole window
        for (int w = 0; w < `FDIV_MEM_DEPTH; w++) begin
            model[w] = $urandom ^ (32'h0101_0101 * w);
            write_word("window fill", word_addr(w), model[w], 1'b0);
        end
        for (int w = 0; w < `FDIV_MEM_DEPTH; w++) begin
            read_word("window readback", word_addr(w), 1'b0, rd);
            check_value("window readback", model[w], rd);
        end

        // Golden set in two batches, split at a random point
        split = 1 + ($urandom % (GOLDEN_N - 1));
        run_batch("batch A", 0, split, 1'b0);
        run_batch("batch B", split, GOLDEN_N - split, 1'b1);

        // Refused accesses leave registers alone
        write_word("unmapped write", 12'h010, 32'h5, 1'b1);
        read_word("unmapped read", 12'h00c, 1'b1, rd);
        write_word("count above limit", `FDIV_ADDR_COUNT, 32'd33, 1'b1);
        read_word("count kept", `FDIV_ADDR_COUNT, 1'b0, rd);
        check_value("count kept", 32'(GOLDEN_N - split), rd);
        write_word("status write", `FDIV_ADDR_STATUS, 32'h0, 1'b1);
        read_word("status kept", `FDIV_ADDR_STATUS, 1'b0, rd);
        check_value("status kept", 32'h2, rd);

        // Empty batch finishes at once and touches no memory
        run_batch("empty batch", 0, 0, 1'b0);
        for (int w = 0; w < `FDIV_MEM_DEPTH; w++) begin
            read_word("memory after empty batch", word_addr(w), 1'b0, rd);
            check_value("memory after empty batch", model[w], rd);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
